// File: sim/hdr_shim_vectors.txt
# name hdr_en dest(hex) user(hex) beats last_keep(hex) corrupt bad_magic seq_err
# corrupt 0 none, 1 magic byte, 2 sequence plus one; counts are totals since reset
single_full     1 3 1 1 ff 0 0 0
single_small    1 5 2 1 0f 0 0 0
multi_spill     1 a 3 4 3f 0 0 0
multi_even      1 1 4 3 0f 0 0 0
untagged        0 2 5 3 1f 0 0 0
untagged_one    0 6 6 1 07 0 0 0
tagged_after    1 7 7 2 ff 0 0 0
bad_magic       1 8 8 2 ff 1 1 0
after_magic     1 9 9 1 01 0 1 1
seq_skip        1 b a 3 7f 2 1 2
after_skip      1 c b 2 3f 0 1 3
resync_ok       1 d c 5 ff 0 1 3
bad_magic_two   1 e d 1 ff 1 2 3
long_packet     1 f e 8 1f 0 2 4
untagged_long   0 4 f 6 ff 0 2 4
back_on         1 0 0 2 07 0 2 4

// File: hdr_shim.f
verilog/hdr_shim_pkg.sv
verilog/hdr_ctrl.sv
verilog/hdr_insert.sv
verilog/hdr_strip.sv
verilog/hdr_shim_top.sv
sim/hdr_shim_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --timing --assert --timescale 1ns/100ps
TOP      = hdr_shim_tb
FILELIST = hdr_shim.f
OBJ_DIR  = obj_dir
PASS_MSG = sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/hdr_shim_tb.sv
// Loops the tx output back into the rx input and checks both paths against a byte-stream model
// Vectors come from sim/hdr_shim_vectors.txt, payload words and back-pressure from $random
module hdr_shim_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import hdr_shim_pkg::*;

  localparam int TIMEOUT = 200;

  logic clk;
  logic rst;
  logic hdr_en;
  data_t tx_s_tdata, tx_m_tdata, rx_s_tdata, rx_m_tdata;
  keep_t tx_s_tkeep, tx_m_tkeep, rx_m_tkeep;
  dest_t tx_s_tdest, tx_m_tdest, rx_m_tdest;
  user_t tx_s_tuser, tx_m_tuser, rx_m_tuser;
  logic tx_s_tlast, tx_s_tvalid, tx_s_tready;
  logic tx_m_tlast, tx_m_tvalid, tx_m_tready;
  logic rx_s_tready, rx_m_tlast, rx_m_tvalid, rx_m_tready;
  seq_t tx_seq;
  cnt_t bad_magic_cnt, seq_err_cnt;

  logic [1:0] corrupt_mode;
  logic       tx_first;
  int         seed = 32'h2363;
  int         stall_seed;
  int         err_count = 0;
  int         check_count = 0;
  int         test_count = 0;
  bit         aborted = 1'b0;
  string      cur_name = "reset";
  dest_t      cur_dest;
  user_t      cur_user;
  hdr_t       cur_hdr;
  seq_t       model_seq = '0;

  data_t      pay_data[$];
  keep_t      pay_keep[$];
  logic [7:0] byte_q[$];
  data_t      exp_tx_data[$], exp_rx_data[$];
  keep_t      exp_tx_keep[$], exp_rx_keep[$];
  logic       exp_tx_last[$], exp_rx_last[$];

  hdr_shim_top i_dut (
    .clk (clk), .rst (rst), .hdr_en (hdr_en),
    .tx_s_tdata (tx_s_tdata), .tx_s_tkeep (tx_s_tkeep), .tx_s_tdest (tx_s_tdest),
    .tx_s_tuser (tx_s_tuser), .tx_s_tlast (tx_s_tlast),
    .tx_s_tvalid (tx_s_tvalid), .tx_s_tready (tx_s_tready),
    .tx_m_tdata (tx_m_tdata), .tx_m_tkeep (tx_m_tkeep), .tx_m_tdest (tx_m_tdest),
    .tx_m_tuser (tx_m_tuser), .tx_m_tlast (tx_m_tlast),
    .tx_m_tvalid (tx_m_tvalid), .tx_m_tready (tx_m_tready),
    .rx_s_tdata (rx_s_tdata), .rx_s_tkeep (tx_m_tkeep), .rx_s_tdest (tx_m_tdest),
    .rx_s_tuser (tx_m_tuser), .rx_s_tlast (tx_m_tlast),
    .rx_s_tvalid (tx_m_tvalid), .rx_s_tready (rx_s_tready),
    .rx_m_tdata (rx_m_tdata), .rx_m_tkeep (rx_m_tkeep), .rx_m_tdest (rx_m_tdest),
    .rx_m_tuser (rx_m_tuser), .rx_m_tlast (rx_m_tlast),
    .rx_m_tvalid (rx_m_tvalid), .rx_m_tready (rx_m_tready),
    .tx_seq (tx_seq), .bad_magic_cnt (bad_magic_cnt), .seq_err_cnt (seq_err_cnt)
  );

  assign tx_m_tready = rx_s_tready;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random sink stall on the rx output with ready about three cycles in four
  initial begin
    stall_seed = seed;
    rx_m_tready <= 1'b0;
    forever begin
      @(posedge clk);
      rx_m_tready <= ($random(stall_seed) & 3) != 0;
    end
  end

  // Marks the first tx_m beat of each packet, which is the header beat when tagging
  always @(posedge clk) begin
    if (rst) begin
      tx_first <= 1'b1;
    end else if (tx_m_tvalid && tx_m_tready) begin
      tx_first <= tx_m_tlast;
    end
  end

  // Loopback with optional damage to the header beat
  always_comb begin
    rx_s_tdata = tx_m_tdata;
    if (tx_first && hdr_en && corrupt_mode == 2'd1) begin
      rx_s_tdata[HDR_MAGIC_LSB +: 8] = ~tx_m_tdata[HDR_MAGIC_LSB +: 8];
    end else if (tx_first && hdr_en && corrupt_mode == 2'd2) begin
      rx_s_tdata[HDR_SEQ_LSB +: SEQ_WIDTH] = tx_m_tdata[HDR_SEQ_LSB +: SEQ_WIDTH] + 8'd1;
    end
  end

  function automatic data_t byte_mask(keep_t k);
    data_t m;
    m = '0;
    for (int b = 0; b < KEEP_WIDTH; b++) begin
      if (k[b]) m[b*8 +: 8] = 8'hFF;
    end
    return m;
  endfunction

  task automatic check_data(string what, data_t exp, data_t act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_keep(string what, keep_t exp, keep_t act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_hdr(string what, hdr_t exp, hdr_t act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_cnt(string what, cnt_t exp, cnt_t act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %0d, actual %0d", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_seq(string what, seq_t exp, seq_t act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %0d, actual %0d", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_dest(string what, dest_t exp, dest_t act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_user(string what, user_t exp, user_t act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", what, exp, act);
      err_count++;
    end
  endtask

  task automatic check_last(string what, logic exp, logic act);
    check_count++;
    if (act !== exp) begin
      $display("error %s: expected %b, actual %b", what, exp, act);
      err_count++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst && tx_m_tvalid && tx_m_tready) begin
      if (exp_tx_data.size() == 0) begin
        $display("%s: tx_m sent a beat that was not expected", cur_name);
        err_count++;
      end else begin
        if (tx_first && hdr_en) begin
          check_hdr({cur_name, " tx header"}, cur_hdr, tx_m_tdata[HDR_WIDTH-1:0]);
        end
        check_keep({cur_name, " tx tkeep"}, exp_tx_keep[0], tx_m_tkeep);
        check_data({cur_name, " tx tdata"}, exp_tx_data[0] & byte_mask(exp_tx_keep[0]),
                   tx_m_tdata & byte_mask(exp_tx_keep[0]));
        check_last({cur_name, " tx tlast"}, exp_tx_last[0], tx_m_tlast);
        check_dest({cur_name, " tx tdest"}, cur_dest, tx_m_tdest);
        check_user({cur_name, " tx tuser"}, cur_user, tx_m_tuser);
        void'(exp_tx_data.pop_front());
        void'(exp_tx_keep.pop_front());
        void'(exp_tx_last.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && rx_m_tvalid && rx_m_tready) begin
      if (exp_rx_data.size() == 0) begin
        $display("%s: rx_m sent a beat that was not expected", cur_name);
        err_count++;
      end else begin
        check_keep({cur_name, " rx tkeep"}, exp_rx_keep[0], rx_m_tkeep);
        check_data({cur_name, " rx tdata"}, exp_rx_data[0] & byte_mask(exp_rx_keep[0]),
                   rx_m_tdata & byte_mask(exp_rx_keep[0]));
        check_last({cur_name, " rx tlast"}, exp_rx_last[0], rx_m_tlast);
        check_dest({cur_name, " rx tdest"}, cur_dest, rx_m_tdest);
        check_user({cur_name, " rx tuser"}, cur_user, rx_m_tuser);
        void'(exp_rx_data.pop_front());
        void'(exp_rx_keep.pop_front());
        void'(exp_rx_last.pop_front());
      end
    end
  end

  // Packs the byte stream into full words from the low byte up
  task automatic pack_words(input bit to_tx);
    int n;
    int nw;
    data_t d;
    keep_t k;
    n = byte_q.size();
    nw = (n + 7) / 8;
    for (int w = 0; w < nw; w++) begin
      d = '0;
      k = '0;
      for (int b = 0; b < KEEP_WIDTH; b++) begin
        if (w * 8 + b < n) begin
          d[b*8 +: 8] = byte_q[w*8 + b];
          k[b] = 1'b1;
        end
      end
      if (to_tx) begin
        exp_tx_data.push_back(d);
        exp_tx_keep.push_back(k);
        exp_tx_last.push_back(w == nw - 1);
      end else begin
        exp_rx_data.push_back(d);
        exp_rx_keep.push_back(k);
        exp_rx_last.push_back(w == nw - 1);
      end
    end
  endtask

  task automatic send_packet();
    int waited;
    for (int i = 0; i < pay_data.size() && !aborted; i++) begin
      tx_s_tdata  <= pay_data[i];
      tx_s_tkeep  <= pay_keep[i];
      tx_s_tdest  <= cur_dest;
      tx_s_tuser  <= cur_user;
      tx_s_tlast  <= (i == pay_data.size() - 1);
      tx_s_tvalid <= 1'b1;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
      end while (!tx_s_tready && waited < TIMEOUT);
      if (!tx_s_tready) begin
        $display("%s: tx_s never became ready for beat %0d", cur_name, i);
        err_count++;
        aborted = 1'b1;
      end
    end
    tx_s_tvalid <= 1'b0;
    tx_s_tlast  <= 1'b0;
  endtask

  task automatic run_test(string name, int en, int dest, int user, int beats, int last_keep,
                          int mode, int exp_bad, int exp_seq);
    int errs_before;
    int waited;
    data_t d;
    keep_t k;
    errs_before = err_count;
    cur_name = name;
    cur_dest = dest_t'(dest);
    cur_user = user_t'(user);
    hdr_en       <= (en != 0);
    corrupt_mode <= 2'(mode);
    // The rx side sees hdr_en through a register, so let it settle
    repeat (3) @(posedge clk);
    pay_data.delete();
    pay_keep.delete();
    byte_q.delete();
    for (int i = 0; i < beats; i++) begin
      d = {$random(seed), $random(seed)};
      k = (i == beats - 1) ? keep_t'(last_keep) : '1;
      d = d & byte_mask(k);
      pay_data.push_back(d);
      pay_keep.push_back(k);
      for (int b = 0; b < KEEP_WIDTH; b++) begin
        if (k[b]) byte_q.push_back(d[b*8 +: 8]);
      end
    end
    pack_words(1'b0);
    if (en != 0) begin
      cur_hdr = {12'h000, cur_dest, model_seq, HDR_MAGIC};
      byte_q.push_front(cur_hdr[31:24]);
      byte_q.push_front(cur_hdr[23:16]);
      byte_q.push_front(cur_hdr[15:8]);
      byte_q.push_front(cur_hdr[7:0]);
      model_seq++;
    end
    pack_words(1'b1);
    send_packet();
    waited = 0;
    while (!aborted && (exp_tx_data.size() != 0 || exp_rx_data.size() != 0) &&
           waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!aborted && (exp_tx_data.size() != 0 || exp_rx_data.size() != 0)) begin
      $display("%s: packet was not fully delivered in time", name);
      err_count++;
      aborted = 1'b1;
    end
    @(posedge clk);
    check_cnt({name, " bad_magic_cnt"}, cnt_t'(exp_bad), bad_magic_cnt);
    check_cnt({name, " seq_err_cnt"}, cnt_t'(exp_seq), seq_err_cnt);
    check_seq({name, " tx_seq"}, model_seq, tx_seq);
    test_count++;
    if (err_count == errs_before) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail, %0d errors", name, err_count - errs_before);
    end
  endtask

  initial begin
    int fd;
    int got;
    string line;
    string name;
    int en, dest, user, beats, lkeep, mode, ebad, eseq;
    rst          <= 1'b1;
    hdr_en       <= 1'b0;
    corrupt_mode <= 2'd0;
    tx_s_tdata   <= '0;
    tx_s_tkeep   <= '0;
    tx_s_tdest   <= '0;
    tx_s_tuser   <= '0;
    tx_s_tlast   <= 1'b0;
    tx_s_tvalid  <= 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    fd = $fopen("sim/hdr_shim_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/hdr_shim_vectors.txt");
      err_count++;
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          got = $sscanf(line, "%s %d %h %h %d %h %d %d %d",
                        name, en, dest, user, beats, lkeep, mode, ebad, eseq);
          if (got == 9) begin
            run_test(name, en, dest, user, beats, lkeep, mode, ebad, eseq);
          end else begin
            $display("vector line could not be read: %s", line);
            err_count++;
          end
        end
      end
      $fclose(fd);
    end
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0 && test_count > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog/hdr_shim_top.sv
// Header shim with a tagging transmit path and a stripping receive path
// hdr_en switches both paths and must only change between packets
module hdr_shim_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hdr_en,

  input  hdr_shim_pkg::data_t  tx_s_tdata,
  input  hdr_shim_pkg::keep_t  tx_s_tkeep,
  input  hdr_shim_pkg::dest_t  tx_s_tdest,
  input  hdr_shim_pkg::user_t  tx_s_tuser,
  input  logic                 tx_s_tlast,
  input  logic                 tx_s_tvalid,
  output logic                 tx_s_tready,

  output hdr_shim_pkg::data_t  tx_m_tdata,
  output hdr_shim_pkg::keep_t  tx_m_tkeep,
  output hdr_shim_pkg::dest_t  tx_m_tdest,
  output hdr_shim_pkg::user_t  tx_m_tuser,
  output logic                 tx_m_tlast,
  output logic                 tx_m_tvalid,
  input  logic                 tx_m_tready,

  input  hdr_shim_pkg::data_t  rx_s_tdata,
  input  hdr_shim_pkg::keep_t  rx_s_tkeep,
  input  hdr_shim_pkg::dest_t  rx_s_tdest,
  input  hdr_shim_pkg::user_t  rx_s_tuser,
  input  logic                 rx_s_tlast,
  input  logic                 rx_s_tvalid,
  output logic                 rx_s_tready,

  output hdr_shim_pkg::data_t  rx_m_tdata,
  output hdr_shim_pkg::keep_t  rx_m_tkeep,
  output hdr_shim_pkg::dest_t  rx_m_tdest,
  output hdr_shim_pkg::user_t  rx_m_tuser,
  output logic                 rx_m_tlast,
  output logic                 rx_m_tvalid,
  input  logic                 rx_m_tready,

  output hdr_shim_pkg::seq_t   tx_seq,
  output hdr_shim_pkg::cnt_t   bad_magic_cnt,
  output hdr_shim_pkg::cnt_t   seq_err_cnt
);
  import hdr_shim_pkg::*;

  hdr_t tx_hdr;
  logic tx_hdr_valid;
  logic tx_hdr_ready;
  hdr_t rx_hdr;
  logic rx_hdr_take;
  logic rx_has_hdr;

  hdr_ctrl i_ctrl (
    .clk           (clk),
    .rst           (rst),
    .hdr_en        (hdr_en),
    .tx_dest       (tx_s_tdest),
    .tx_hdr        (tx_hdr),
    .tx_hdr_valid  (tx_hdr_valid),
    .tx_hdr_ready  (tx_hdr_ready),
    .tx_seq        (tx_seq),
    .rx_has_hdr    (rx_has_hdr),
    .rx_hdr        (rx_hdr),
    .rx_hdr_take   (rx_hdr_take),
    .bad_magic_cnt (bad_magic_cnt),
    .seq_err_cnt   (seq_err_cnt)
  );

  hdr_insert i_insert (
    .clk       (clk),
    .rst       (rst),
    .s_tdata   (tx_s_tdata),  .s_tkeep  (tx_s_tkeep),  .s_tdest (tx_s_tdest),
    .s_tuser   (tx_s_tuser),  .s_tlast  (tx_s_tlast),
    .s_tvalid  (tx_s_tvalid), .s_tready (tx_s_tready),
    .hdr       (tx_hdr),
    .hdr_valid (tx_hdr_valid),
    .hdr_ready (tx_hdr_ready),
    .m_tdata   (tx_m_tdata),  .m_tkeep  (tx_m_tkeep),  .m_tdest (tx_m_tdest),
    .m_tuser   (tx_m_tuser),  .m_tlast  (tx_m_tlast),
    .m_tvalid  (tx_m_tvalid), .m_tready (tx_m_tready)
  );

  // The receive side reports its header validity but the checker only needs the take strobe
  hdr_strip i_strip (
    .clk       (clk),
    .rst       (rst),
    .has_hdr   (rx_has_hdr),
    .s_tdata   (rx_s_tdata),  .s_tkeep  (rx_s_tkeep),  .s_tdest (rx_s_tdest),
    .s_tuser   (rx_s_tuser),  .s_tlast  (rx_s_tlast),
    .s_tvalid  (rx_s_tvalid), .s_tready (rx_s_tready),
    .hdr       (rx_hdr),
    .hdr_valid (),
    .hdr_take  (rx_hdr_take),
    .m_tdata   (rx_m_tdata),  .m_tkeep  (rx_m_tkeep),  .m_tdest (rx_m_tdest),
    .m_tuser   (rx_m_tuser),  .m_tlast  (rx_m_tlast),
    .m_tvalid  (rx_m_tvalid), .m_tready (rx_m_tready)
  );

endmodule

// File: verilog/hdr_strip.sv
// Strips the 32-bit header from each tagged packet and moves the payload down by half a word
// has_hdr must be stable from before a packet's first beat until its tlast
module hdr_strip (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 has_hdr,

  input  hdr_shim_pkg::data_t  s_tdata,
  input  hdr_shim_pkg::keep_t  s_tkeep,
  input  hdr_shim_pkg::dest_t  s_tdest,
  input  hdr_shim_pkg::user_t  s_tuser,
  input  logic                 s_tlast,
  input  logic                 s_tvalid,
  output logic                 s_tready,

  output hdr_shim_pkg::hdr_t   hdr,
  output logic                 hdr_valid,
  output logic                 hdr_take,

  output hdr_shim_pkg::data_t  m_tdata,
  output hdr_shim_pkg::keep_t  m_tkeep,
  output hdr_shim_pkg::dest_t  m_tdest,
  output hdr_shim_pkg::user_t  m_tuser,
  output logic                 m_tlast,
  output logic                 m_tvalid,
  input  logic                 m_tready
);
  import hdr_shim_pkg::*;

  shift_state_t         state;
  hdr_t                 hdr_r;
  logic [HDR_WIDTH-1:0] rest_data;
  logic [HDR_KEEP-1:0]  rest_keep;
  dest_t                dest_r;
  user_t                user_r;
  logic                 spill;
  logic                 s_fire;

  assign spill  = |s_tkeep[KEEP_WIDTH-1:HDR_KEEP];
  assign s_fire = s_tvalid && s_tready;

  // A header beat with more words behind it produces no output, so it is taken
  // without waiting for the sink. A single-beat packet does produce output
  assign s_tready = (state == S_HDR && has_hdr && !s_tlast) ||
                    (state != S_LST && m_tready);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_HDR;
    end else begin
      case (state)
        S_HDR: begin
          if (s_fire && !s_tlast) begin
            state <= has_hdr ? S_MID : S_FWD;
          end
        end
        S_MID: begin
          if (s_fire && s_tlast) begin
            state <= spill ? S_LST : S_HDR;
          end
        end
        S_LST: begin
          if (m_tready) begin
            state <= S_HDR;
          end
        end
        default: begin
          if (s_fire && s_tlast) begin
            state <= S_HDR;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_data <= s_tdata[DATA_WIDTH-1:HDR_WIDTH];
      rest_keep <= s_tkeep[KEEP_WIDTH-1:HDR_KEEP];
    end
    if (s_fire && state == S_HDR) begin
      hdr_r  <= s_tdata[HDR_WIDTH-1:0];
      dest_r <= s_tdest;
      user_r <= s_tuser;
    end
  end

  always_comb begin
    m_tdata  = s_tdata;
    m_tkeep  = s_tkeep;
    m_tlast  = s_tlast;
    m_tvalid = s_tvalid;
    case (state)
      S_HDR: begin
        if (has_hdr) begin
          // Only a one-word packet leaves anything on its first beat
          m_tdata  = {{HDR_WIDTH{1'b0}}, s_tdata[DATA_WIDTH-1:HDR_WIDTH]};
          m_tkeep  = {{HDR_KEEP{1'b0}}, s_tkeep[KEEP_WIDTH-1:HDR_KEEP]};
          m_tvalid = s_tvalid && s_tlast;
        end
      end
      S_MID: begin
        m_tdata = {s_tdata[HDR_WIDTH-1:0], rest_data};
        m_tkeep = {s_tkeep[HDR_KEEP-1:0], rest_keep};
        m_tlast = s_tlast && !spill;
      end
      S_LST: begin
        m_tdata  = {{HDR_WIDTH{1'b0}}, rest_data};
        m_tkeep  = {{HDR_KEEP{1'b0}}, rest_keep};
        m_tlast  = 1'b1;
        m_tvalid = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign m_tdest = (state == S_HDR) ? s_tdest : dest_r;
  assign m_tuser = (state == S_HDR) ? s_tuser : user_r;

  // The header is live from the first beat until the packet is done
  assign hdr       = (state == S_HDR) ? s_tdata[HDR_WIDTH-1:0] : hdr_r;
  assign hdr_valid = (state == S_HDR && has_hdr && s_tvalid) ||
                     state == S_MID || state == S_LST;
  assign hdr_take  = (state == S_HDR) && has_hdr && s_fire;

  // has_hdr is registered from the level input and must already be settled
  a_take_stable: assert property (@(posedge clk) disable iff (rst)
    hdr_take |-> (state == S_HDR && has_hdr && $past(has_hdr)));

endmodule

// File: verilog/hdr_insert.sv
// Puts a 32-bit header in front of each packet and moves the payload up by half a word
// hdr_valid is sampled on the first beat and must hold until the packet's tlast
module hdr_insert (
  input  logic                 clk,
  input  logic                 rst,

  input  hdr_shim_pkg::data_t  s_tdata,
  input  hdr_shim_pkg::keep_t  s_tkeep,
  input  hdr_shim_pkg::dest_t  s_tdest,
  input  hdr_shim_pkg::user_t  s_tuser,
  input  logic                 s_tlast,
  input  logic                 s_tvalid,
  output logic                 s_tready,

  input  hdr_shim_pkg::hdr_t   hdr,
  input  logic                 hdr_valid,
  output logic                 hdr_ready,

  output hdr_shim_pkg::data_t  m_tdata,
  output hdr_shim_pkg::keep_t  m_tkeep,
  output hdr_shim_pkg::dest_t  m_tdest,
  output hdr_shim_pkg::user_t  m_tuser,
  output logic                 m_tlast,
  output logic                 m_tvalid,
  input  logic                 m_tready
);
  import hdr_shim_pkg::*;

  shift_state_t         state;
  logic [HDR_WIDTH-1:0] rest_data;
  logic [HDR_KEEP-1:0]  rest_keep;
  dest_t                dest_r;
  user_t                user_r;
  logic                 spill;
  logic                 s_fire;

  // Any byte in the upper half of a last beat has to go out in an extra word
  assign spill  = |s_tkeep[KEEP_WIDTH-1:HDR_KEEP];
  assign s_fire = s_tvalid && s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_HDR;
    end else begin
      case (state)
        S_HDR: begin
          if (s_fire) begin
            if (hdr_valid) begin
              if (s_tlast) begin
                state <= spill ? S_LST : S_HDR;
              end else begin
                state <= S_MID;
              end
            end else begin
              state <= s_tlast ? S_HDR : S_FWD;
            end
          end
        end
        S_MID: begin
          if (s_fire && s_tlast) begin
            state <= spill ? S_LST : S_HDR;
          end
        end
        S_LST: begin
          if (m_tready) begin
            state <= S_HDR;
          end
        end
        default: begin
          if (s_fire && s_tlast) begin
            state <= S_HDR;
          end
        end
      endcase
    end
  end

  // The upper half of every accepted word is carried into the next output word
  always_ff @(posedge clk) begin
    if (s_fire) begin
      rest_data <= s_tdata[DATA_WIDTH-1:HDR_WIDTH];
      rest_keep <= s_tkeep[KEEP_WIDTH-1:HDR_KEEP];
    end
    if (s_fire && state == S_HDR) begin
      dest_r <= s_tdest;
      user_r <= s_tuser;
    end
  end

  always_comb begin
    m_tdata  = s_tdata;
    m_tkeep  = s_tkeep;
    m_tlast  = s_tlast;
    m_tvalid = s_tvalid;
    case (state)
      S_HDR: begin
        if (hdr_valid) begin
          m_tdata = {s_tdata[HDR_WIDTH-1:0], hdr};
          m_tkeep = {s_tkeep[HDR_KEEP-1:0], {HDR_KEEP{1'b1}}};
          m_tlast = s_tlast && !spill;
        end
      end
      S_MID: begin
        m_tdata = {s_tdata[HDR_WIDTH-1:0], rest_data};
        m_tkeep = {s_tkeep[HDR_KEEP-1:0], rest_keep};
        m_tlast = s_tlast && !spill;
      end
      S_LST: begin
        m_tdata  = {{(DATA_WIDTH-HDR_WIDTH){1'b0}}, rest_data};
        m_tkeep  = {{(KEEP_WIDTH-HDR_KEEP){1'b0}}, rest_keep};
        m_tlast  = 1'b1;
        m_tvalid = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign m_tdest   = (state == S_HDR) ? s_tdest : dest_r;
  assign m_tuser   = (state == S_HDR) ? s_tuser : user_r;
  assign s_tready  = (state == S_LST) ? 1'b0 : m_tready;
  assign hdr_ready = (state == S_HDR) && hdr_valid && s_tvalid && m_tready;

  // The spill beat is only entered with bytes left over from the last input word
  a_lst_nonempty: assert property (@(posedge clk) disable iff (rst)
    (state == S_LST) |-> (m_tvalid && m_tkeep != '0));

endmodule

// File: verilog/hdr_ctrl.sv
// Builds transmit headers and checks received ones against magic byte and sequence
// Error counters saturate at all ones and only clear on reset
module hdr_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hdr_en,
  input  hdr_shim_pkg::dest_t  tx_dest,

  output hdr_shim_pkg::hdr_t   tx_hdr,
  output logic                 tx_hdr_valid,
  input  logic                 tx_hdr_ready,

  output hdr_shim_pkg::seq_t   tx_seq,
  output logic                 rx_has_hdr,

  input  hdr_shim_pkg::hdr_t   rx_hdr,
  input  logic                 rx_hdr_take,

  output hdr_shim_pkg::cnt_t   bad_magic_cnt,
  output hdr_shim_pkg::cnt_t   seq_err_cnt
);
  import hdr_shim_pkg::*;

  rx_state_t                             rx_state;
  seq_t                                  exp_seq;
  logic [HDR_SEQ_LSB-1:HDR_MAGIC_LSB]    rx_magic;
  seq_t                                  rx_seq;
  logic                                  magic_ok;
  logic                                  seq_miss;

  // Transmit header, the sequence advances once the header has gone out
  always_comb begin
    tx_hdr = '0;
    tx_hdr[HDR_SEQ_LSB-1:HDR_MAGIC_LSB] = HDR_MAGIC;
    tx_hdr[HDR_DEST_LSB-1:HDR_SEQ_LSB]  = tx_seq;
    tx_hdr[HDR_PAD_LSB-1:HDR_DEST_LSB]  = tx_dest;
  end

  assign tx_hdr_valid = hdr_en;

  assign rx_magic = rx_hdr[HDR_SEQ_LSB-1:HDR_MAGIC_LSB];
  assign rx_seq   = rx_hdr[HDR_DEST_LSB-1:HDR_SEQ_LSB];
  assign magic_ok = (rx_magic == HDR_MAGIC);
  // No expectation exists until the first good header has been seen
  assign seq_miss = (rx_state == RX_LOCK) && (rx_seq != exp_seq);

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_seq        <= '0;
      rx_has_hdr    <= 1'b0;
      rx_state      <= RX_HUNT;
      exp_seq       <= '0;
      bad_magic_cnt <= '0;
      seq_err_cnt   <= '0;
    end else begin
      rx_has_hdr <= hdr_en;

      if (tx_hdr_ready) begin
        tx_seq <= tx_seq + 1'b1;
      end

      if (rx_hdr_take) begin
        if (!magic_ok) begin
          // Garbage header, keep the current expectation
          if (bad_magic_cnt != '1) begin
            bad_magic_cnt <= bad_magic_cnt + 1'b1;
          end
        end else begin
          // Lock on, advance, or resync to the received value
          rx_state <= RX_LOCK;
          exp_seq  <= rx_seq + 1'b1;
          if (seq_miss && seq_err_cnt != '1) begin
            seq_err_cnt <= seq_err_cnt + 1'b1;
          end
        end
      end
    end
  end

  a_bad_magic_no_wrap: assert property (@(posedge clk) disable iff (rst)
    bad_magic_cnt >= $past(bad_magic_cnt));

  a_seq_err_no_wrap: assert property (@(posedge clk) disable iff (rst)
    seq_err_cnt >= $past(seq_err_cnt));

endmodule

// File: verilog/hdr_shim_pkg.sv
// Widths, header layout and state types shared by the header shim
// Widths are fixed and the datapaths assume the header is exactly half a stream word
package hdr_shim_pkg;

  localparam int DATA_WIDTH = 64;
  localparam int HDR_WIDTH  = 32;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;
  localparam int HDR_KEEP   = HDR_WIDTH / 8;
  localparam int DEST_WIDTH = 4;
  localparam int USER_WIDTH = 4;
  localparam int SEQ_WIDTH  = 8;
  localparam int CNT_WIDTH  = 16;

  // Header fields from the low end, everything above the dest field is zero
  localparam int HDR_MAGIC_LSB = 0;
  localparam int HDR_SEQ_LSB   = 8;
  localparam int HDR_DEST_LSB  = HDR_SEQ_LSB + SEQ_WIDTH;
  localparam int HDR_PAD_LSB   = HDR_DEST_LSB + DEST_WIDTH;

  localparam logic [HDR_SEQ_LSB-HDR_MAGIC_LSB-1:0] HDR_MAGIC = 8'hA5;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [KEEP_WIDTH-1:0] keep_t;
  typedef logic [DEST_WIDTH-1:0] dest_t;
  typedef logic [USER_WIDTH-1:0] user_t;
  typedef logic [HDR_WIDTH-1:0]  hdr_t;
  typedef logic [SEQ_WIDTH-1:0]  seq_t;
  typedef logic [CNT_WIDTH-1:0]  cnt_t;

  // Shift machine shared by both datapaths
  typedef enum logic [1:0] {
    S_HDR,
    S_MID,
    S_LST,
    S_FWD
  } shift_state_t;

  typedef enum logic {
    RX_HUNT,
    RX_LOCK
  } rx_state_t;

endpackage
